//--- logic/mpu_bus_cfg.svh
`ifndef MPU_BUS_CFG_SVH
`define MPU_BUS_CFG_SVH

// Width of the shared address/data byte
`define MPU_DATA_WIDTH 8

// Full host address, high byte on mpu_ah and low byte on the AD lines
`define MPU_ADDR_WIDTH 16

// Byte registers in the block
`define REG_COUNT 32

// Index bits taken from the low address byte
`define REG_IDX_WIDTH 5

// Request buffer entries between bus slave and register file
`define REQ_FIFO_DEPTH 4

// High address byte that selects this block
// Any other page is ignored by the slave
`define REG_PAGE 8'h00

`endif

//--- logic/mpu_bus_pkg.sv
package mpu_bus_pkg;

  // Bus slave progress through one host cycle
  // ADDR_LATCHED waits for a strobe after ALE
  // WRITE_PEND holds until the write strobe is released
  // READ_WAIT waits for the register file response
  // READ_DRIVE keeps data on the bus until the read strobe ends
  typedef enum logic [2:0] {
    IDLE         = 3'd0,
    ADDR_LATCHED = 3'd1,
    WRITE_PEND   = 3'd2,
    READ_WAIT    = 3'd3,
    READ_DRIVE   = 3'd4
  } slave_state_t;

  // Host strobes after the two flop synchronizer
  // Levels keep the pin polarity, pulses last one clock
  typedef struct packed {
    // Synchronized read strobe, low while reading
    logic rd_n;
    // Synchronized write strobe, low while writing
    logic wr_n;
    // Synchronized address latch enable
    logic ale;
    // First clock with ALE high
    logic ale_rise;
    // Start of a read data phase
    logic rd_fall;
    // End of a write data phase
    logic wr_rise;
  } bus_sync_t;

endpackage

//--- logic/reg_access_pkg.sv
`include "mpu_bus_cfg.svh"

package reg_access_pkg;

  // Register access opcode
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } reg_op_t;

  // One byte access toward the register file
  typedef struct packed {
    // Read or write
    reg_op_t                    op;
    // Register index inside the selected page
    logic [`REG_IDX_WIDTH-1:0]  idx;
    // Write data, don't care for reads
    logic [`MPU_DATA_WIDTH-1:0] wdata;
  } reg_req_t;

  // Read response back to the bus slave
  typedef struct packed {
    // Register contents at the time of the read
    logic [`MPU_DATA_WIDTH-1:0] rdata;
  } reg_rsp_t;

endpackage

//--- logic/mpu_bus_slave.sv
`include "mpu_bus_cfg.svh"

module mpu_bus_slave (
  input  logic                                      clk,
  input  logic                                      arst_n,
  input  logic                                      mpu_rd_n,
  input  logic                                      mpu_wr_n,
  input  logic                                      mpu_ale,
  input  logic [`MPU_ADDR_WIDTH-`MPU_DATA_WIDTH-1:0] mpu_ah,
  input  logic [`MPU_DATA_WIDTH-1:0]                mpu_ad_in,
  output logic [`MPU_DATA_WIDTH-1:0]                mpu_ad_out,
  output logic                                      mpu_ad_oe,
  output logic                                      req_valid,
  output reg_access_pkg::reg_req_t                  req_data,
  input  logic                                      req_ready,
  input  logic                                      rsp_valid,
  input  reg_access_pkg::reg_rsp_t                  rsp_data,
  output logic                                      rsp_ready
);

  // Strobe shift registers, bit 1 is the synchronized level
  // Bit 2 is the previous level for edge detection
  logic [2:0] rd_n_sync;
  logic [2:0] wr_n_sync;
  logic [2:0] ale_sync;

  // Address and data pins delayed to line up with the strobes
  logic [`MPU_DATA_WIDTH-1:0]                ad_s1;
  logic [`MPU_DATA_WIDTH-1:0]                ad_s2;
  logic [`MPU_ADDR_WIDTH-`MPU_DATA_WIDTH-1:0] ah_s1;
  logic [`MPU_ADDR_WIDTH-`MPU_DATA_WIDTH-1:0] ah_s2;

  // Last data byte seen while the write strobe was low
  logic [`MPU_DATA_WIDTH-1:0] wr_hold;

  mpu_bus_pkg::bus_sync_t    sync;
  mpu_bus_pkg::slave_state_t state;
  mpu_bus_pkg::slave_state_t state_d;

  // Latched index and page miss flag of the current cycle
  logic [`REG_IDX_WIDTH-1:0] idx_q;
  logic                      ignore_q;

  // Decisions of the FSM for this clock
  logic                      latch_addr;
  logic                      issue;
  reg_access_pkg::reg_op_t   issue_op;
  logic                      drive_start;
  logic                      drive_end;

  // Inactive strobe levels after reset
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rd_n_sync <= 3'b111;
      wr_n_sync <= 3'b111;
      ale_sync  <= 3'b000;
    end
    else
    begin
      rd_n_sync <= {rd_n_sync[1:0], mpu_rd_n};
      wr_n_sync <= {wr_n_sync[1:0], mpu_wr_n};
      ale_sync  <= {ale_sync[1:0], mpu_ale};
    end
  end

  // AD and AH only change while the strobes are idle, two stages match the strobe delay
  always_ff @(posedge clk)
  begin
    ad_s1 <= mpu_ad_in;
    ad_s2 <= ad_s1;
    ah_s1 <= mpu_ah;
    ah_s2 <= ah_s1;
    if (!wr_n_sync[1])
      wr_hold <= ad_s2;
  end

  always_comb
  begin
    sync.rd_n     = rd_n_sync[1];
    sync.wr_n     = wr_n_sync[1];
    sync.ale      = ale_sync[1];
    sync.ale_rise = ale_sync[1] & ~ale_sync[2];
    sync.rd_fall  = ~rd_n_sync[1] & rd_n_sync[2];
    sync.wr_rise  = wr_n_sync[1] & ~wr_n_sync[2];
  end

  // Only a cycle on our own page takes the response
  assign rsp_ready = (state == mpu_bus_pkg::READ_WAIT) && !ignore_q;

  always_comb
  begin
    state_d     = state;
    latch_addr  = 1'b0;
    issue       = 1'b0;
    issue_op    = reg_access_pkg::OP_READ;
    drive_start = 1'b0;
    drive_end   = 1'b0;
    case (state)
      mpu_bus_pkg::IDLE:
      begin
        if (sync.ale_rise)
        begin
          latch_addr = 1'b1;
          state_d    = mpu_bus_pkg::ADDR_LATCHED;
        end
      end
      mpu_bus_pkg::ADDR_LATCHED:
      begin
        // A second ALE simply replaces the address
        if (sync.ale_rise)
          latch_addr = 1'b1;
        else if (!sync.ale && !sync.wr_n)
          state_d = mpu_bus_pkg::WRITE_PEND;
        else if (sync.rd_fall)
        begin
          issue   = !ignore_q;
          state_d = mpu_bus_pkg::READ_WAIT;
        end
      end
      mpu_bus_pkg::WRITE_PEND:
      begin
        // Data is taken when the host releases the strobe
        if (sync.wr_rise)
        begin
          issue    = !ignore_q;
          issue_op = reg_access_pkg::OP_WRITE;
          state_d  = mpu_bus_pkg::IDLE;
        end
      end
      mpu_bus_pkg::READ_WAIT:
      begin
        if (rsp_valid && rsp_ready)
        begin
          // Strobe already gone, drop the data
          if (sync.rd_n)
            state_d = mpu_bus_pkg::IDLE;
          else
          begin
            drive_start = 1'b1;
            state_d     = mpu_bus_pkg::READ_DRIVE;
          end
        end
        else if (ignore_q && sync.rd_n)
          state_d = mpu_bus_pkg::IDLE;
      end
      mpu_bus_pkg::READ_DRIVE:
      begin
        if (sync.rd_n)
        begin
          drive_end = 1'b1;
          state_d   = mpu_bus_pkg::IDLE;
        end
      end
      default:
        state_d = mpu_bus_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state     <= mpu_bus_pkg::IDLE;
      ignore_q  <= 1'b0;
      req_valid <= 1'b0;
      mpu_ad_oe <= 1'b0;
    end
    else
    begin
      state <= state_d;
      if (latch_addr)
        ignore_q <= (ah_s2 != `REG_PAGE);
      // Single output slot, host spacing keeps it free for the next issue
      if (issue)
        req_valid <= 1'b1;
      else if (req_ready)
        req_valid <= 1'b0;
      if (drive_start)
        mpu_ad_oe <= 1'b1;
      else if (drive_end)
        mpu_ad_oe <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (latch_addr)
      idx_q <= ad_s2[`REG_IDX_WIDTH-1:0];
    if (issue)
    begin
      req_data.op    <= issue_op;
      req_data.idx   <= idx_q;
      req_data.wdata <= wr_hold;
    end
    if (drive_start)
      mpu_ad_out <= rsp_data.rdata;
  end

endmodule

//--- logic/req_fifo.sv
`include "mpu_bus_cfg.svh"

module req_fifo #(
  parameter int DEPTH = `REQ_FIFO_DEPTH,
  parameter int WIDTH = $bits(reg_access_pkg::reg_req_t)
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             in_valid,
  input  logic [WIDTH-1:0] in_data,
  output logic             in_ready,
  output logic             out_valid,
  output logic [WIDTH-1:0] out_data,
  input  logic             out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic push;
  logic pop;

  // Full blocks the writer even when a pop happens the same clock
  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  // Head entry shows without a read cycle
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // Count unchanged when both happen
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

endmodule

//--- logic/reg_file.sv
`include "mpu_bus_cfg.svh"

module reg_file (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     req_valid,
  input  reg_access_pkg::reg_req_t req_data,
  output logic                     req_ready,
  output logic                     rsp_valid,
  output reg_access_pkg::reg_rsp_t rsp_data,
  input  logic                     rsp_ready
);

  // Host visible byte registers
  logic [`MPU_DATA_WIDTH-1:0] regs [`REG_COUNT];

  logic take;
  logic is_write;
  logic is_read;

  // One response slot, no new request while it is occupied
  assign req_ready = !rsp_valid;
  assign take      = req_valid && req_ready;
  assign is_write  = take && (req_data.op == reg_access_pkg::OP_WRITE);
  assign is_read   = take && (req_data.op == reg_access_pkg::OP_READ);

  // Registers come up as zero
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= '0;
    end
    else if (is_write)
    begin
      regs[req_data.idx] <= req_data.wdata;
    end
  end

  // Response valid one clock after the read transfer
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      rsp_valid <= 1'b0;
    else if (is_read)
      rsp_valid <= 1'b1;
    else if (rsp_ready)
      rsp_valid <= 1'b0;
  end

  // Read data captured at the transfer edge
  always_ff @(posedge clk)
  begin
    if (is_read)
      rsp_data.rdata <= regs[req_data.idx];
  end

endmodule

//--- logic/main.sv
`include "mpu_bus_cfg.svh"

module main (
  input  logic                                      clk,
  input  logic                                      arst_n,
  input  logic                                      mpu_rd_n,
  input  logic                                      mpu_wr_n,
  input  logic                                      mpu_ale,
  input  logic [`MPU_ADDR_WIDTH-`MPU_DATA_WIDTH-1:0] mpu_ah,
  input  logic [`MPU_DATA_WIDTH-1:0]                mpu_ad_in,
  output logic [`MPU_DATA_WIDTH-1:0]                mpu_ad_out,
  output logic                                      mpu_ad_oe
);

  // Slave to FIFO
  logic                     req_valid;
  logic                     req_ready;
  reg_access_pkg::reg_req_t req_data;

  // FIFO to register file
  logic                     fifo_valid;
  logic                     fifo_ready;
  reg_access_pkg::reg_req_t fifo_data;

  // Read responses back to the slave
  logic                     rsp_valid;
  logic                     rsp_ready;
  reg_access_pkg::reg_rsp_t rsp_data;

  mpu_bus_slave u_slave (
    .clk        (clk),
    .arst_n     (arst_n),
    .mpu_rd_n   (mpu_rd_n),
    .mpu_wr_n   (mpu_wr_n),
    .mpu_ale    (mpu_ale),
    .mpu_ah     (mpu_ah),
    .mpu_ad_in  (mpu_ad_in),
    .mpu_ad_out (mpu_ad_out),
    .mpu_ad_oe  (mpu_ad_oe),
    .req_valid  (req_valid),
    .req_data   (req_data),
    .req_ready  (req_ready),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data),
    .rsp_ready  (rsp_ready)
  );

  // Keeps writes and reads in host order
  req_fifo #(
    .DEPTH (`REQ_FIFO_DEPTH),
    .WIDTH ($bits(reg_access_pkg::reg_req_t))
  ) u_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (req_valid),
    .in_data   (req_data),
    .in_ready  (req_ready),
    .out_valid (fifo_valid),
    .out_data  (fifo_data),
    .out_ready (fifo_ready)
  );

  reg_file u_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (fifo_valid),
    .req_data  (fifo_data),
    .req_ready (fifo_ready),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data),
    .rsp_ready (rsp_ready)
  );

endmodule

//--- sim/main_tb.sv
`include "mpu_bus_cfg.svh"

module main_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_NS       = 20;
  localparam int RESET_CYCLES = 5;
  // Bus cycles of the reset reads, words, overwrite, page, ordering and random tests
  localparam int BUS_CYCLES   = 32 + 64 + 62 + 24 + 20 + 200;
  // A write takes 22 clocks and a read 30 so 40 per cycle bounds the run
  localparam int LIMIT_CLOCKS = BUS_CYCLES * 40 + RESET_CYCLES + 200;

  logic                                       clk;
  logic                                       arst_n;
  logic                                       mpu_rd_n;
  logic                                       mpu_wr_n;
  logic                                       mpu_ale;
  logic [`MPU_ADDR_WIDTH-`MPU_DATA_WIDTH-1:0] mpu_ah;
  logic [`MPU_DATA_WIDTH-1:0]                 mpu_ad_in;
  logic [`MPU_DATA_WIDTH-1:0]                 mpu_ad_out;
  logic                                       mpu_ad_oe;

  // One read as the host saw it
  typedef struct packed {
    logic [`MPU_ADDR_WIDTH-1:0] addr;
    logic                       oe;
    logic [`MPU_DATA_WIDTH-1:0] data;
  } read_sample_t;

  read_sample_t               samples [$];
  logic [`MPU_DATA_WIDTH-1:0] shadow [`REG_COUNT];
  int                         errors = 0;
  int                         checks = 0;
  integer                     seed = 32'h359c;
  // Clocks since the host last held the read strobe low
  int                         rd_high_clocks = 0;

  // Host pin levels in the same layout as the synchronized view in the slave
  mpu_bus_pkg::bus_sync_t host_view;
  assign host_view = '{rd_n: mpu_rd_n, wr_n: mpu_wr_n, ale: mpu_ale,
                       ale_rise: 1'b0, rd_fall: 1'b0, wr_rise: 1'b0};

  main uut (
    .clk        (clk),
    .arst_n     (arst_n),
    .mpu_rd_n   (mpu_rd_n),
    .mpu_wr_n   (mpu_wr_n),
    .mpu_ale    (mpu_ale),
    .mpu_ah     (mpu_ah),
    .mpu_ad_in  (mpu_ad_in),
    .mpu_ad_out (mpu_ad_out),
    .mpu_ad_oe  (mpu_ad_oe)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  function automatic logic in_page(input logic [`MPU_ADDR_WIDTH-1:0] addr);
    return addr[`MPU_ADDR_WIDTH-1:`MPU_DATA_WIDTH] == `REG_PAGE;
  endfunction

  // Shadow byte of an in-page address
  function automatic logic [`MPU_DATA_WIDTH-1:0] expected_read(
    input logic [`MPU_ADDR_WIDTH-1:0] addr
  );
    return shadow[addr[`REG_IDX_WIDTH-1:0]];
  endfunction

  function automatic logic [`MPU_ADDR_WIDTH-1:0] page_addr(
    input logic [`MPU_ADDR_WIDTH-`MPU_DATA_WIDTH-1:0] page,
    input int                                         idx
  );
    return {page, 8'(idx)};
  endfunction

  // Pins change 2 ns after a rising edge
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic drive_address(input logic [`MPU_ADDR_WIDTH-1:0] addr);
    mpu_ah    = addr[`MPU_ADDR_WIDTH-1:`MPU_DATA_WIDTH];
    mpu_ad_in = addr[`MPU_DATA_WIDTH-1:0];
    mpu_ale   = 1'b1;
    step(4);
    mpu_ale   = 1'b0;
  endtask

  task automatic write8(input logic [`MPU_ADDR_WIDTH-1:0] addr,
                        input logic [`MPU_DATA_WIDTH-1:0] data);
    if (in_page(addr))
      shadow[addr[`REG_IDX_WIDTH-1:0]] = data;
    drive_address(addr);
    mpu_ad_in = data;
    mpu_wr_n  = 1'b0;
    step(6);
    mpu_wr_n  = 1'b1;
    step(12);
  endtask

  // Two byte writes with the low byte first
  task automatic write16(input logic [`MPU_ADDR_WIDTH-1:0] addr, input logic [15:0] data);
    write8(addr, data[7:0]);
    write8(addr + 1'b1, data[15:8]);
  endtask

  task automatic read8(input logic [`MPU_ADDR_WIDTH-1:0] addr);
    read_sample_t s;
    drive_address(addr);
    mpu_rd_n = 1'b0;
    step(14);
    // Last clock of the strobe
    s.addr   = addr;
    s.oe     = mpu_ad_oe;
    s.data   = mpu_ad_out;
    mpu_rd_n = 1'b1;
    samples.push_back(s);
    step(12);
  endtask

  // Compares every read sample against the shadow registers
  always @(posedge clk)
  begin
    read_sample_t s;
    while (samples.size() > 0)
    begin
      s = samples.pop_front();
      if (in_page(s.addr))
      begin
        checks += 2;
        assert (s.oe === 1'b1)
        else
        begin
          errors++;
          $display("** Error: mpu_ad_oe at addr %h: got %h, expected %h", s.addr, s.oe, 1'b1);
        end
        assert (s.data === expected_read(s.addr))
        else
        begin
          errors++;
          $display("** Error: mpu_ad_out at addr %h: got %h, expected %h",
                   s.addr, s.data, expected_read(s.addr));
        end
      end
      else
      begin
        checks++;
        // Off-page cycles never drive the bus
        assert (s.oe === 1'b0)
        else
        begin
          errors++;
          $display("** Error: mpu_ad_oe at addr %h: got %h, expected %h", s.addr, s.oe, 1'b0);
        end
      end
    end
  end

  // Bus released no later than 3 clocks after the read strobe goes inactive
  always @(posedge clk)
  begin
    if (!host_view.rd_n)
      rd_high_clocks = 0;
    else
      rd_high_clocks++;
    if (arst_n && rd_high_clocks > 3)
    begin
      assert (mpu_ad_oe === 1'b0)
      else
      begin
        errors++;
        $display("Error: bus still driven %0d clocks after the read strobe was released",
                 rd_high_clocks);
      end
    end
  end

  initial
  begin
    #(LIMIT_CLOCKS * CLK_NS);
    $display("Error: run did not finish within %0d clocks", LIMIT_CLOCKS);
    $display("Test failures found");
    $finish;
  end

  initial
  begin
    logic [15:0]                                word;
    logic [31:0]                                r;
    logic [`MPU_ADDR_WIDTH-`MPU_DATA_WIDTH-1:0] page;
    logic [`MPU_ADDR_WIDTH-`MPU_DATA_WIDTH-1:0] off_page;
    arst_n    = 1'b0;
    mpu_rd_n  = 1'b1;
    mpu_wr_n  = 1'b1;
    mpu_ale   = 1'b0;
    mpu_ah    = '0;
    mpu_ad_in = '0;
    off_page  = `REG_PAGE ^ 8'h5a;
    for (int i = 0; i < `REG_COUNT; i++)
      shadow[i] = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 arst_n = 1'b1;
    step(3);

    // After reset the bus is released and all registers read zero
    checks++;
    assert (mpu_ad_oe === 1'b0)
    else
    begin
      errors++;
      $display("** Error: mpu_ad_oe while idle: got %h, expected %h", mpu_ad_oe, 1'b0);
    end
    for (int i = 0; i < `REG_COUNT; i++)
      read8(page_addr(`REG_PAGE, i));

    // Word writes at even addresses
    for (int i = 0; i < `REG_COUNT; i += 2)
    begin
      word = 16'($random(seed));
      write16(page_addr(`REG_PAGE, i), word);
    end
    for (int i = 0; i < `REG_COUNT; i++)
      read8(page_addr(`REG_PAGE, i));

    // Byte overwrite of registers 0 to 29 while 30 and 31 keep word data
    for (int i = 0; i < 30; i++)
      write8(page_addr(`REG_PAGE, i), (i % 2 == 0) ? 8'h00 : 8'hff);
    for (int i = 0; i < `REG_COUNT; i++)
      read8(page_addr(`REG_PAGE, i));

    // Page decode
    for (int i = 0; i < 8; i++)
      write8(page_addr(off_page, i * 4), 8'ha5 ^ 8'(i));
    for (int i = 0; i < 8; i++)
    begin
      read8(page_addr(`REG_PAGE, i * 4));
      read8(page_addr(off_page, i * 4));
    end

    // Repeated writes to one address where the newest must win
    for (int b = 0; b < 4; b++)
    begin
      for (int n = 0; n < 4; n++)
        write8(page_addr(`REG_PAGE, b * 8 + 3), 8'($random(seed)));
      read8(page_addr(`REG_PAGE, b * 8 + 3));
    end

    // Random traffic with three in four cycles in page
    for (int i = 0; i < 200; i++)
    begin
      r    = $random(seed);
      page = r[31:24];
      if (page == `REG_PAGE)
        page = ~page;
      if (r[1] | r[2])
        page = `REG_PAGE;
      if (r[0])
        write8(page_addr(page, int'(r[12:8])), r[23:16]);
      else
        read8(page_addr(page, int'(r[12:8])));
    end

    while (samples.size() > 0)
      @(posedge clk);
    step(2);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+logic
logic/mpu_bus_pkg.sv
logic/reg_access_pkg.sv
logic/mpu_bus_slave.sv
logic/req_fifo.sv
logic/reg_file.sv
logic/main.sv
sim/main_tb.sv

//--- Makefile
# Verilator build and run of the MPU bus register block

VERILATOR ?= verilator
TOP       ?= main_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failures found
VFLAGS    ?= --assert --timing --timescale 1ns/100ps

SIM_BIN := $(BUILD_DIR)/$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh sim/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)

# The log decides, a crash or the fail message fails the target
run: build
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
